/* src/fpu_lite_pkg.sv */
`default_nettype none

package fpu_lite_pkg;

  ////////////////////////////////////////
  // Operand types

  // Single precision encoding and its fields
  typedef logic [31:0] fp32_t;
  typedef logic [7:0]  fp_exp_t;
  typedef logic [22:0] fp_sig_t;

  // NV DZ OF UF NX, high to low
  typedef logic [4:0] fp_flags_t;

  // RISC-V classify mask
  typedef logic [9:0] fp_class_t;

  ////////////////////////////////////////
  // Operations

  typedef enum logic [1:0] {
    OP_CLASS  = 2'd0,
    OP_CMP    = 2'd1,
    OP_MINMAX = 2'd2,
    OP_SGNJ   = 2'd3
  } fpu_op_e;

  typedef logic [1:0] fpu_param_t;

  localparam fpu_param_t PARAM_EQ    = 2'd0;
  localparam fpu_param_t PARAM_LT    = 2'd1;
  localparam fpu_param_t PARAM_LE    = 2'd2;
  localparam fpu_param_t PARAM_MIN   = 2'd0;
  localparam fpu_param_t PARAM_MAX   = 2'd1;
  localparam fpu_param_t PARAM_SGNJ  = 2'd0;
  localparam fpu_param_t PARAM_SGNJN = 2'd1;
  localparam fpu_param_t PARAM_SGNJX = 2'd2;

  ////////////////////////////////////////
  // Bit positions

  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  localparam int CLASS_NEG_INF  = 0;
  localparam int CLASS_NEG_NORM = 1;
  localparam int CLASS_NEG_SUB  = 2;
  localparam int CLASS_NEG_ZERO = 3;
  localparam int CLASS_POS_ZERO = 4;
  localparam int CLASS_POS_SUB  = 5;
  localparam int CLASS_POS_NORM = 6;
  localparam int CLASS_POS_INF  = 7;
  localparam int CLASS_SNAN     = 8;
  localparam int CLASS_QNAN     = 9;

  localparam fp32_t CANON_NAN = 32'h7fc00000;

endpackage

`default_nettype wire

/* src/fpu_operand_if.sv */
`default_nettype none

// One decoded request, from the input register to the processing stage
interface fpu_operand_if import fpu_lite_pkg::*; ();

  logic       valid;
  fpu_op_e    op;
  fpu_param_t param;
  fp32_t      a;
  fp32_t      b;
  fp_class_t  a_class;
  fp_class_t  b_class;

  modport src (
    output valid,
    output op,
    output param,
    output a,
    output b,
    output a_class,
    output b_class
  );

  modport dst (
    input valid,
    input op,
    input param,
    input a,
    input b,
    input a_class,
    input b_class
  );

endinterface

`default_nettype wire

/* src/fpu_decode.sv */
`default_nettype none

module fpu_decode import fpu_lite_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       req_valid_i,
  input  fpu_op_e    req_op_i,
  input  fpu_param_t req_param_i,
  input  fp32_t      operand_a_i,
  input  fp32_t      operand_b_i,

  fpu_operand_if.src dec_o
);

  // Field split and class bits for one operand
  function automatic fp_class_t classify(fp32_t v);
    logic      sign;
    fp_exp_t   exp_f;
    fp_sig_t   frac;
    logic      exp_zero;
    logic      exp_ones;
    logic      frac_zero;
    fp_class_t cls;

    sign      = v[31];
    exp_f     = v[30:23];
    frac      = v[22:0];
    exp_zero  = (exp_f == '0);
    exp_ones  = (exp_f == '1);
    frac_zero = (frac == '0);
    cls       = '0;

    if (exp_ones && !frac_zero) begin
      // Top fraction bit tells quiet from signaling
      if (frac[22]) begin
        cls[CLASS_QNAN] = 1'b1;
      end else begin
        cls[CLASS_SNAN] = 1'b1;
      end
    end else if (exp_ones) begin
      cls[CLASS_NEG_INF] = sign;
      cls[CLASS_POS_INF] = !sign;
    end else if (exp_zero && frac_zero) begin
      cls[CLASS_NEG_ZERO] = sign;
      cls[CLASS_POS_ZERO] = !sign;
    end else if (exp_zero) begin
      cls[CLASS_NEG_SUB] = sign;
      cls[CLASS_POS_SUB] = !sign;
    end else begin
      cls[CLASS_NEG_NORM] = sign;
      cls[CLASS_POS_NORM] = !sign;
    end
    return cls;
  endfunction

  logic       valid_q;
  fpu_op_e    op_q;
  fpu_param_t param_q;
  fp32_t      a_q;
  fp32_t      b_q;

  ////////////////////////////////////////
  // Request register

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  // Payload follows the inputs every cycle
  always_ff @(posedge clk_i) begin
    op_q    <= req_op_i;
    param_q <= req_param_i;
    a_q     <= operand_a_i;
    b_q     <= operand_b_i;
  end

  ////////////////////////////////////////
  // Decoded view

  assign dec_o.valid   = valid_q;
  assign dec_o.op      = op_q;
  assign dec_o.param   = param_q;
  assign dec_o.a       = a_q;
  assign dec_o.b       = b_q;
  assign dec_o.a_class = classify(a_q);
  assign dec_o.b_class = classify(b_q);

endmodule

`default_nettype wire

/* src/fpu_misc_unit.sv */
`default_nettype none

module fpu_misc_unit import fpu_lite_pkg::*; (
  fpu_operand_if.dst dec_i,

  output logic       res_valid_o,
  output fp32_t      res_value_o,
  output fp_flags_t  res_flags_o
);

  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic any_nan;
  logic any_snan;
  logic both_zero;

  logic lt_ordered;
  logic eq_ordered;
  logic cmp_lt;
  logic cmp_eq;
  logic cmp_signaling;
  logic cmp_invalid;
  logic cmp_bit;

  logic  minmax_max;
  logic  pick_b;
  fp32_t minmax_value;

  logic  sgnj_sign;
  fp32_t sgnj_value;

  ////////////////////////////////////////
  // Operand properties

  assign a_snan   = dec_i.a_class[CLASS_SNAN];
  assign b_snan   = dec_i.b_class[CLASS_SNAN];
  assign a_nan    = a_snan | dec_i.a_class[CLASS_QNAN];
  assign b_nan    = b_snan | dec_i.b_class[CLASS_QNAN];
  assign any_nan  = a_nan | b_nan;
  assign any_snan = a_snan | b_snan;

  // +0 and -0 compare equal
  assign both_zero = (dec_i.a_class[CLASS_NEG_ZERO] | dec_i.a_class[CLASS_POS_ZERO]) &
                     (dec_i.b_class[CLASS_NEG_ZERO] | dec_i.b_class[CLASS_POS_ZERO]);

  ////////////////////////////////////////
  // Compare

  // Ordering assuming neither operand is NaN
  always_comb begin
    if (both_zero) begin
      lt_ordered = 1'b0;
    end else if (dec_i.a[31] != dec_i.b[31]) begin
      lt_ordered = dec_i.a[31];
    end else if (!dec_i.a[31]) begin
      lt_ordered = dec_i.a[30:0] < dec_i.b[30:0];
    end else begin
      // Both negative, larger magnitude is smaller
      lt_ordered = dec_i.b[30:0] < dec_i.a[30:0];
    end
  end

  assign eq_ordered = both_zero | (dec_i.a == dec_i.b);
  assign cmp_lt     = !any_nan & lt_ordered;
  assign cmp_eq     = !any_nan & eq_ordered;

  // LT and LE trap on quiet NaN too
  assign cmp_signaling = (dec_i.param != PARAM_EQ);
  assign cmp_invalid   = cmp_signaling ? any_nan : any_snan;

  always_comb begin
    unique case (dec_i.param)
      PARAM_EQ: cmp_bit = cmp_eq;
      PARAM_LT: cmp_bit = cmp_lt;
      PARAM_LE: cmp_bit = cmp_lt | cmp_eq;
      default:  cmp_bit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Min and max

  assign minmax_max = (dec_i.param != PARAM_MIN);

  // Equal values only differ in sign for the zero pair, -0 is the smaller
  assign pick_b = eq_ordered ? (minmax_max == dec_i.a[31]) : (minmax_max == lt_ordered);

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_value = CANON_NAN;
    end else if (a_nan) begin
      minmax_value = dec_i.b;
    end else if (b_nan) begin
      minmax_value = dec_i.a;
    end else begin
      minmax_value = pick_b ? dec_i.b : dec_i.a;
    end
  end

  ////////////////////////////////////////
  // Sign injection

  always_comb begin
    unique case (dec_i.param)
      PARAM_SGNJ:  sgnj_sign = dec_i.b[31];
      PARAM_SGNJN: sgnj_sign = !dec_i.b[31];
      PARAM_SGNJX: sgnj_sign = dec_i.a[31] ^ dec_i.b[31];
      default:     sgnj_sign = dec_i.a[31];
    endcase
  end

  // NaN payload of a is kept as is
  assign sgnj_value = {sgnj_sign, dec_i.a[30:0]};

  ////////////////////////////////////////
  // Result select

  always_comb begin
    res_flags_o = '0;
    unique case (dec_i.op)
      OP_CLASS: begin
        res_value_o = {22'd0, dec_i.a_class};
      end
      OP_CMP: begin
        res_value_o = {31'd0, cmp_bit};
        res_flags_o[FLAG_NV] = cmp_invalid;
      end
      OP_MINMAX: begin
        res_value_o = minmax_value;
        res_flags_o[FLAG_NV] = any_snan;
      end
      default: begin
        res_value_o = sgnj_value;
      end
    endcase
  end

  assign res_valid_o = dec_i.valid;

endmodule

`default_nettype wire

/* src/fpu_result_stage.sv */
`default_nettype none

module fpu_result_stage import fpu_lite_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      res_valid_i,
  input  fp32_t     res_value_i,
  input  fp_flags_t res_flags_i,

  output logic      resp_valid_o,
  output fp32_t     resp_value_o,
  output fp_flags_t resp_flags_o
);

  logic      valid_q;
  fp32_t     value_q;
  fp_flags_t flags_q;

  ////////////////////////////////////////
  // Output registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= res_valid_i;
    end
  end

  // Hold the last response between strobes
  always_ff @(posedge clk_i) begin
    if (res_valid_i) begin
      value_q <= res_value_i;
      flags_q <= res_flags_i;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_value_o = value_q;
  assign resp_flags_o = flags_q;

endmodule

`default_nettype wire

/* src/fpu_lite.sv */
`default_nettype none

module fpu_lite import fpu_lite_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       req_valid_i,
  input  fpu_op_e    req_op_i,
  input  fpu_param_t req_param_i,
  input  fp32_t      operand_a_i,
  input  fp32_t      operand_b_i,

  output logic       resp_valid_o,
  output fp32_t      resp_value_o,
  output fp_flags_t  resp_flags_o
);

  logic      res_valid;
  fp32_t     res_value;
  fp_flags_t res_flags;

  fpu_operand_if dec_if ();

  ////////////////////////////////////////
  // Stage 1, request register and decode

  fpu_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_param_i (req_param_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .dec_o       (dec_if)
  );

  ////////////////////////////////////////
  // Stage 2, operation and output register

  fpu_misc_unit u_misc (
    .dec_i       (dec_if),
    .res_valid_o (res_valid),
    .res_value_o (res_value),
    .res_flags_o (res_flags)
  );

  fpu_result_stage u_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_valid_i  (res_valid),
    .res_value_i  (res_value),
    .res_flags_i  (res_flags),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o),
    .resp_flags_o (resp_flags_o)
  );

endmodule

`default_nettype wire

/* bench/fpu_lite_assert.sv */
`default_nettype none

module fpu_lite_assert import fpu_lite_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      req_valid_i,
  input logic      resp_valid_o,
  input fp_flags_t resp_flags_o
);

  logic seen_req_q;

  // Set once the first request has been taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_req_q <= 1'b0;
    end else if (req_valid_i) begin
      seen_req_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Protocol

  a_reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !resp_valid_o)
    else $error("resp_valid_o is high while reset is asserted");

  a_no_early_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_req_q |-> !resp_valid_o)
    else $error("resp_valid_o is high before any request arrived");

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o == $past(req_valid_i, 2))
    else $error("resp_valid_o does not follow req_valid_i by two cycles");

  // Only NV can be raised by these operations
  a_flags_nv_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> resp_flags_o[FLAG_DZ:FLAG_NX] == 4'b0000)
    else $error("a flag other than NV is set on a response");

endmodule

bind fpu_lite fpu_lite_assert u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_valid_i  (req_valid_i),
  .resp_valid_o (resp_valid_o),
  .resp_flags_o (resp_flags_o)
);

`default_nettype wire

/* bench/fpu_lite_tb.sv */
`default_nettype none

module fpu_lite_tb import fpu_lite_pkg::*; ();

  localparam int RAND_COUNT  = 300;
  localparam int DRAIN_LIMIT = 20;

  // Zeros, infinities, quiet NaN with payload, signaling NaN, min subnormal, 1.0
  localparam fp32_t SPECIALS [8] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
    32'h7fc1_2345, 32'h7f80_0001, 32'h0000_0001, 32'h3f80_0000
  };

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  fpu_op_e    req_op_i;
  fpu_param_t req_param_i;
  fp32_t      operand_a_i;
  fp32_t      operand_b_i;
  logic       resp_valid_o;
  fp32_t      resp_value_o;
  fp_flags_t  resp_flags_o;

  logic [31:0] rng_state = 32'hcb186dbf;
  fp32_t       exp_value_q [$];
  fp_flags_t   exp_flags_q [$];
  string       exp_name_q [$];

  fpu_lite uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_param_i  (req_param_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o),
    .resp_flags_o (resp_flags_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reference model

  function automatic logic is_nan(fp32_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(fp32_t x);
    return is_nan(x) && !x[22];
  endfunction

  // Signed magnitude as a two's complement key where -0 and +0 map to one value
  function automatic logic signed [32:0] order_key(fp32_t x);
    logic signed [32:0] mag;
    mag = {2'b00, x[30:0]};
    return x[31] ? -mag : mag;
  endfunction

  function automatic int class_index(fp32_t x);
    if (is_nan(x)) return x[22] ? 9 : 8;
    if (x[30:23] == 8'hff) return x[31] ? 0 : 7;
    if (x[30:0] == 31'd0) return x[31] ? 3 : 4;
    if (x[30:23] == 8'h00) return x[31] ? 2 : 5;
    return x[31] ? 1 : 6;
  endfunction

  function automatic void model_result(input fpu_op_e op, input fpu_param_t param,
                                       input fp32_t a, input fp32_t b,
                                       output fp32_t value, output fp_flags_t flags);
    logic nan_any;
    logic lt;
    logic eq;
    nan_any = is_nan(a) || is_nan(b);
    lt      = !nan_any && (order_key(a) < order_key(b));
    eq      = !nan_any && (order_key(a) == order_key(b));
    flags   = 5'b00000;
    case (op)
      OP_CLASS: value = 32'd1 << class_index(a);
      OP_CMP: begin
        value = {31'd0, (param == PARAM_EQ) ? eq : (param == PARAM_LT) ? lt : (lt || eq)};
        flags[FLAG_NV] = (param == PARAM_EQ) ? (is_snan(a) || is_snan(b)) : nan_any;
      end
      OP_MINMAX: begin
        flags[FLAG_NV] = is_snan(a) || is_snan(b);
        if (is_nan(a) && is_nan(b)) value = CANON_NAN;
        else if (is_nan(a)) value = b;
        else if (is_nan(b)) value = a;
        else if (eq) value = ((param == PARAM_MIN) == a[31]) ? a : b;
        else value = ((param == PARAM_MIN) == lt) ? a : b;
      end
      default: begin
        if (param == PARAM_SGNJ) value = {b[31], a[30:0]};
        else if (param == PARAM_SGNJN) value = {!b[31], a[30:0]};
        else value = {a[31] ^ b[31], a[30:0]};
      end
    endcase
  endfunction

  function automatic string op_name(fpu_op_e op, fpu_param_t param);
    case (op)
      OP_CLASS:
        return "class";
      OP_CMP:
        return (param == PARAM_EQ) ? "cmp_eq" : (param == PARAM_LT) ? "cmp_lt" : "cmp_le";
      OP_MINMAX:
        return (param == PARAM_MIN) ? "min" : "max";
      default:
        return (param == PARAM_SGNJ) ? "sgnj" : (param == PARAM_SGNJN) ? "sgnjn" : "sgnjx";
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = lcg_step(rng_state);
    // Fold the high half down since the low LCG bits repeat quickly
    r = rng_state ^ (rng_state >> 15);
  endtask

  task automatic pick_operand(output fp32_t v);
    logic [31:0] r;
    next_rand(r);
    if (r[1:0] == 2'd0) v = SPECIALS[r[10:8]] ^ {r[31], 31'd0};
    else if (r[1:0] == 2'd1) v = {r[31], 8'hff, r[22:0]};
    else v = r;
  endtask

  function automatic fpu_param_t legal_param(fpu_op_e op, logic [1:0] bits);
    if (op == OP_MINMAX) return {1'b0, bits[0]};
    if (op != OP_CLASS && bits == 2'd3) return 2'd0;
    return bits;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Called on a falling edge and returns on the next one
  task automatic send(input fpu_op_e op, input fpu_param_t param,
                      input fp32_t a, input fp32_t b);
    fp32_t     want_value;
    fp_flags_t want_flags;
    model_result(op, param, a, b, want_value, want_flags);
    exp_value_q.push_back(want_value);
    exp_flags_q.push_back(want_flags);
    exp_name_q.push_back(op_name(op, param));
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_param_i = param;
    operand_a_i = a;
    operand_b_i = b;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Response check

  always @(negedge clk_i) begin : check_resp
    fp32_t     want_value;
    fp_flags_t want_flags;
    string     name;
    if (rst_ni && resp_valid_o) begin
      if (exp_value_q.size() == 0) begin
        stop_run("A response arrived with no request pending");
      end else begin
        want_value = exp_value_q.pop_front();
        want_flags = exp_flags_q.pop_front();
        name       = exp_name_q.pop_front();
        assert (resp_value_o == want_value)
          else stop_run($sformatf("Mismatch %s value: expected %h, actual %h",
                                  name, want_value, resp_value_o));
        assert (resp_flags_o == want_flags)
          else stop_run($sformatf("Mismatch %s flags: expected %b, actual %b",
                                  name, want_flags, resp_flags_o));
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence

  initial begin : run
    int          i;
    int          j;
    int          k;
    int          waited;
    logic [31:0] r;
    fpu_op_e     op;
    fpu_param_t  param;
    fp32_t       a;
    fp32_t       b;
    rst_ni      = 1'b0;
    req_valid_i = 1'b1;
    req_op_i    = OP_CLASS;
    req_param_i = 2'd0;
    operand_a_i = 32'd0;
    operand_b_i = 32'd0;
    // Strobes while in reset must never reach the output
    repeat (12) @(negedge clk_i);
    req_valid_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);

    // Specials and their negations reach all ten class bits
    for (i = 0; i < 16; i++) begin
      send(OP_CLASS, 2'd0, SPECIALS[i % 8] ^ ((i >= 8) ? 32'h8000_0000 : 32'h0), 32'd0);
    end

    // Every special pair for each compare, min/max and sign injection variant
    for (k = 0; k < 8; k++) begin
      op    = (k < 3) ? OP_CMP : (k < 5) ? OP_MINMAX : OP_SGNJ;
      param = fpu_param_t'((k < 3) ? k : (k < 5) ? k - 3 : k - 5);
      for (i = 0; i < 8; i++) begin
        for (j = 0; j < 8; j++) begin
          send(op, param, SPECIALS[i], SPECIALS[j]);
        end
      end
    end

    for (i = 0; i < RAND_COUNT; i++) begin
      next_rand(r);
      op    = fpu_op_e'(r[1:0]);
      param = legal_param(op, r[3:2]);
      pick_operand(a);
      case (r[5:4])
        2'd0:    b = a;
        2'd1:    b = a ^ 32'h8000_0000;
        default: pick_operand(b);
      endcase
      if (r[7:6] == 2'd0) @(negedge clk_i);
      send(op, param, a, b);
    end

    waited = 0;
    while (exp_value_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_value_q.size() != 0) begin
      stop_run("Timed out waiting for the remaining responses");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* fpu_lite.f */
src/fpu_lite_pkg.sv
src/fpu_operand_if.sv
src/fpu_decode.sv
src/fpu_misc_unit.sv
src/fpu_result_stage.sv
src/fpu_lite.sv
bench/fpu_lite_assert.sv
bench/fpu_lite_tb.sv

/* Makefile */
# Verilator simulation of the FPU side unit

VERILATOR ?= verilator
TOP       ?= fpu_lite_tb
FILELIST  ?= fpu_lite.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -j 0

.PHONY: sim clean

# The simulator exits nonzero when the testbench stops on an error
sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
